//--- hdl/apciBusPkg.sv
// Amiga to PCI bridge bus definitions
// Widths, byte lanes and the packed cycle and bus drive records
package apciBusPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int addrWidth  = 32;
  localparam int dataWidth  = 32;
  localparam int laneWidth  = 8;
  // One IDSEL line per slot, taken from A20..A16
  localparam int idselWidth = 5;
  localparam int idselLo    = 16;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Byte address, same on both sides of the bridge
  typedef logic [addrWidth-1:0]  addrT;
  typedef logic [dataWidth-1:0]  dataT;
  typedef logic [laneWidth-1:0]  laneT;
  typedef logic [idselWidth-1:0] idselT;

  ////////////////////////////////////////////////////////////
  // Records
  ////////////////////////////////////////////////////////////

  // One cycle as posted by a master
  // rnw is seen from the requesting master
  typedef struct packed {
    addrT addr;
    dataT wdata;
    logic rnw;
    logic cfg;
    logic dma;
  } cycleReqT;

  // Split tri-state bus, data plus output enable
  typedef struct packed {
    dataT data;
    logic oe;
  } busDriveT;

endpackage

//--- hdl/apciCtrlPkg.sv
// Amiga to PCI bridge control definitions
// Master identifiers and cycle sequencer states
package apciCtrlPkg;

  // Owner of the shared AD bus
  typedef enum logic [1:0] {
    mstNone = 2'd0,
    mstCpu  = 2'd1,
    mstDma  = 2'd2
  } masterT;

  // Address phase then data phase per granted cycle
  typedef enum logic [1:0] {
    seqIdle = 2'd0,
    seqAddr = 2'd1,
    seqData = 2'd2
  } seqStateT;

endpackage

//--- hdl/pciBusArbiter.sv
// PCI AD bus arbiter
// Round-robin grant between the CPU and DMA masters
// Grant holds until the sequencer reports the cycle done
`timescale 1ns/1ps

module pciBusArbiter
  import apciBusPkg::*;
  import apciCtrlPkg::*;
#(
  parameter bit startWithDma = 1'b0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     cpuReq,
  input  logic     dmaReq,
  input  cycleReqT cpuCycle,
  input  cycleReqT dmaCycle,
  input  logic     cycleDone,
  output masterT   grant,
  output cycleReqT grantCycle
);

  masterT lastServed;
  masterT nextGrant;

  ////////////////////////////////////////////////////////////
  // Winner selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    nextGrant = mstNone;
    if (cpuReq && dmaReq) begin
      // Tie goes to the master not served last
      nextGrant = (lastServed == mstCpu) ? mstDma : mstCpu;
    end else if (cpuReq) begin
      nextGrant = mstCpu;
    end else if (dmaReq) begin
      nextGrant = mstDma;
    end
  end

  ////////////////////////////////////////////////////////////
  // Grant register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      grant      <= mstNone;
      // Pretend the other master went last so the first tie is ours
      lastServed <= startWithDma ? mstCpu : mstDma;
    end else if (grant == mstNone) begin
      grant <= nextGrant;
      if (nextGrant != mstNone) begin
        lastServed <= nextGrant;
      end
    end else if (cycleDone) begin
      // Bus free again, next grant one cycle later
      grant <= mstNone;
    end
  end

  // Cycle of the current owner
  always_comb begin
    case (grant)
      mstCpu:  grantCycle = cpuCycle;
      mstDma:  grantCycle = dmaCycle;
      default: grantCycle = '0;
    endcase
  end

endmodule

//--- hdl/pciCycleSeq.sv
// PCI cycle sequencer
// One address phase then a data phase held until target ready
// Pulses done and returns the read data of the finished cycle
`timescale 1ns/1ps

module pciCycleSeq
  import apciBusPkg::*;
  import apciCtrlPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  masterT   grant,
  input  cycleReqT grantCycle,
  input  logic     pciTrdy,
  input  dataT     rdataSwapped,
  output logic     phaseA,
  output logic     dataPhase,
  output cycleReqT curCycle,
  output logic     cycleDone,
  output dataT     cycleRdata
);

  seqStateT state;
  logic     startCycle;
  logic     endCycle;

  ////////////////////////////////////////////////////////////
  // Phase decode
  ////////////////////////////////////////////////////////////

  // Grant still set during the done pulse
  // Done blocks a restart of the same cycle
  assign startCycle = (state == seqIdle) && (grant != mstNone) && !cycleDone;

  // Target ready sampled in the data phase
  assign endCycle = (state == seqData) && pciTrdy;

  assign phaseA    = (state == seqAddr);
  assign dataPhase = (state == seqData);

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= seqIdle;
      cycleDone <= 1'b0;
      curCycle  <= '0;
    end else begin
      // Done is a single cycle pulse
      cycleDone <= 1'b0;
      case (state)
        seqIdle: begin
          if (startCycle) begin
            // Freeze the request for both phases
            curCycle <= grantCycle;
            state    <= seqAddr;
          end
        end
        seqAddr: begin
          // Address phase lasts exactly one cycle
          state <= seqData;
        end
        seqData: begin
          // Wait states while the target holds TRDY low
          if (endCycle) begin
            state     <= seqIdle;
            cycleDone <= 1'b1;
          end
        end
        default: begin
          state <= seqIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read data return
  ////////////////////////////////////////////////////////////

  // Swapped word from the buffers, valid with the done pulse
  always_ff @(posedge clk) begin
    if (endCycle) begin
      cycleRdata <= rdataSwapped;
    end
  end

endmodule

//--- hdl/adBuffers.sv
// Address and data buffer control
// Direction, enables and byte swap between the Amiga data bus and AD
// IDSEL capture for configuration cycles
`timescale 1ns/1ps

module adBuffers
  import apciBusPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     phaseA,
  input  logic     dataPhase,
  input  cycleReqT curCycle,
  input  dataT     amigaDataIn,
  input  dataT     pciAdIn,
  output busDriveT pciAd,
  output busDriveT amigaData,
  output logic     addrBufEn,
  output logic     pciDir,
  output idselT    idsel,
  output dataT     rdataSwapped
);

  logic  amigaToPci;
  logic  pciDataEn;
  logic  amigaDataEn;
  idselT idselQ;

  // Lane 0 of one side lands in lane 3 of the other
  function automatic dataT swapLanes(input dataT word);
    laneT [3:0] lanes;
    lanes = word;
    return {lanes[0], lanes[1], lanes[2], lanes[3]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Direction and enables
  ////////////////////////////////////////////////////////////

  // dma rnw  flow
  //  0   0   Amiga -> PCI
  //  0   1   PCI -> Amiga
  //  1   0   PCI -> Amiga
  //  1   1   Amiga -> PCI
  assign amigaToPci = (curCycle.dma == curCycle.rnw);
  assign pciDir     = ~amigaToPci;

  // Address buffers only in the address phase
  assign addrBufEn = phaseA;

  // Data phase drives the receiving side only
  assign pciDataEn   = dataPhase & amigaToPci;
  assign amigaDataEn = dataPhase & ~amigaToPci;

  ////////////////////////////////////////////////////////////
  // Bus drive
  ////////////////////////////////////////////////////////////

  always_comb begin
    // AD muxes address and data
    pciAd.oe       = phaseA | pciDataEn;
    pciAd.data     = phaseA ? curCycle.addr : swapLanes(amigaDataIn);
    // Amiga bus stays off in the address phase
    amigaData.oe   = amigaDataEn;
    amigaData.data = swapLanes(pciAdIn);
  end

  // Read word for the requesting master, from whichever side sources data
  assign rdataSwapped = amigaToPci ? swapLanes(amigaDataIn) : swapLanes(pciAdIn);

  ////////////////////////////////////////////////////////////
  // IDSEL
  ////////////////////////////////////////////////////////////

  // A20..A16 captured in the address phase of config cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      idselQ <= '0;
    end else if (phaseA) begin
      idselQ <= curCycle.cfg ? curCycle.addr[idselLo +: idselWidth] : '0;
    end
  end

  // Presented for the data phase only
  assign idsel = dataPhase ? idselQ : '0;

endmodule

//--- hdl/apciBridgeTop.sv
// Amiga to PCI bridge slice
// Arbiter, cycle sequencer and AD buffer control on one shared AD bus
`timescale 1ns/1ps

module apciBridgeTop
  import apciBusPkg::*;
  import apciCtrlPkg::*;
#(
  parameter bit startWithDma = 1'b0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     cpuReq,
  input  cycleReqT cpuCycle,
  input  logic     dmaReq,
  input  cycleReqT dmaCycle,
  input  logic     pciTrdy,
  input  dataT     pciAdIn,
  input  dataT     amigaDataIn,
  output masterT   grant,
  output logic     cycleDone,
  output dataT     cycleRdata,
  output busDriveT pciAd,
  output busDriveT amigaData,
  output logic     addrBufEn,
  output logic     pciDir,
  output idselT    idsel
);

  cycleReqT grantCycle;
  cycleReqT curCycle;
  logic     phaseA;
  logic     dataPhase;
  dataT     rdataSwapped;

  ////////////////////////////////////////////////////////////
  // Bus ownership
  ////////////////////////////////////////////////////////////

  pciBusArbiter #(
    .startWithDma (startWithDma)
  ) arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .cpuReq     (cpuReq),
    .dmaReq     (dmaReq),
    .cpuCycle   (cpuCycle),
    .dmaCycle   (dmaCycle),
    .cycleDone  (cycleDone),
    .grant      (grant),
    .grantCycle (grantCycle)
  );

  // Phase timing of the granted cycle
  pciCycleSeq seq_i (
    .clk          (clk),
    .rst          (rst),
    .grant        (grant),
    .grantCycle   (grantCycle),
    .pciTrdy      (pciTrdy),
    .rdataSwapped (rdataSwapped),
    .phaseA       (phaseA),
    .dataPhase    (dataPhase),
    .curCycle     (curCycle),
    .cycleDone    (cycleDone),
    .cycleRdata   (cycleRdata)
  );

  ////////////////////////////////////////////////////////////
  // Buffers
  ////////////////////////////////////////////////////////////

  adBuffers buffers_i (
    .clk          (clk),
    .rst          (rst),
    .phaseA       (phaseA),
    .dataPhase    (dataPhase),
    .curCycle     (curCycle),
    .amigaDataIn  (amigaDataIn),
    .pciAdIn      (pciAdIn),
    .pciAd        (pciAd),
    .amigaData    (amigaData),
    .addrBufEn    (addrBufEn),
    .pciDir       (pciDir),
    .idsel        (idsel),
    .rdataSwapped (rdataSwapped)
  );

endmodule

//--- verification/apciBridge_asserts.sv
// Concurrent checks for the Amiga to PCI bridge slice
// Address phase length, exclusive data drive and grant hold
`timescale 1ns/1ps

module apciBridgeAsserts
  import apciCtrlPkg::*;
(
  input logic   clk,
  input logic   rst,
  input logic   phaseA,
  input logic   cycleDone,
  input masterT grant,
  input logic   pciAdOe,
  input logic   amigaDataOe
);

  // Number of failed assertions
  int failCount;

  initial failCount = 0;

  // Address phase is a single cycle
  phaseOnce: assert property (@(posedge clk) disable iff (rst) phaseA |=> !phaseA)
    else begin
      $error("phaseA high for more than one cycle");
      failCount++;
    end

  // Never both data buffers at once
  oeExclusive: assert property (@(posedge clk) disable iff (rst) !(pciAdOe && amigaDataOe))
    else begin
      $error("pciAd and amigaData driven together");
      failCount++;
    end

  // Owner keeps the bus until its done pulse
  grantHold: assert property (@(posedge clk) disable iff (rst)
    (grant != mstNone && !cycleDone) |=> $stable(grant))
    else begin
      $error("grant changed before cycleDone");
      failCount++;
    end

endmodule

//--- verification/apciBridgeTb.sv
// Testbench for the Amiga to PCI bridge slice
// PCI target and Amiga memory models driven from a stimulus table
`timescale 1ns/1ps

module apciBridgeTb
  import apciBusPkg::*;
  import apciCtrlPkg::*;
();

  localparam bit startWithDma = 1'b0;
  localparam int numEntries   = 8;
  localparam int waitLimit    = 50;

  // One table row with expected direction and IDSEL
  typedef struct packed {
    logic       isDma;
    addrT       addr;
    dataT       wdata;
    logic       rnw;
    logic       cfg;
    logic [3:0] waitN;
    dataT       rword;
    logic       expDir;
    idselT      expIdsel;
  } entryT;

  logic     clk;
  logic     rst;
  logic     cpuReq;
  cycleReqT cpuCycle;
  logic     dmaReq;
  cycleReqT dmaCycle;
  logic     pciTrdy;
  dataT     pciAdIn;
  dataT     amigaDataIn;
  masterT   grant;
  logic     cycleDone;
  dataT     cycleRdata;
  busDriveT pciAd;
  busDriveT amigaData;
  logic     addrBufEn;
  logic     pciDir;
  idselT    idsel;

  entryT    tbl [numEntries];
  int       errCount;
  int       assertErrs;
  masterT   lastMst;

  apciBridgeTop #(
    .startWithDma (startWithDma)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .cpuReq      (cpuReq),
    .cpuCycle    (cpuCycle),
    .dmaReq      (dmaReq),
    .dmaCycle    (dmaCycle),
    .pciTrdy     (pciTrdy),
    .pciAdIn     (pciAdIn),
    .amigaDataIn (amigaDataIn),
    .grant       (grant),
    .cycleDone   (cycleDone),
    .cycleRdata  (cycleRdata),
    .pciAd       (pciAd),
    .amigaData   (amigaData),
    .addrBufEn   (addrBufEn),
    .pciDir      (pciDir),
    .idsel       (idsel)
  );

  bind apciBridgeTop apciBridgeAsserts asserts_i (
    .clk         (clk),
    .rst         (rst),
    .phaseA      (phaseA),
    .cycleDone   (cycleDone),
    .grant       (grant),
    .pciAdOe     (pciAd.oe),
    .amigaDataOe (amigaData.oe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference rules and checks
  ////////////////////////////////////////////////////////////

  // AD lane 0 holds Amiga lane 3 and so on
  function automatic dataT byteReverse(input dataT w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic entryT makeEntry(input logic isDma, input addrT addr, input logic rnw,
                                      input logic cfg, input logic expDir, input idselT expIdsel);
    entryT e;
    e.isDma    = isDma;
    e.addr     = addr;
    e.rnw      = rnw;
    e.cfg      = cfg;
    e.expDir   = expDir;
    e.expIdsel = expIdsel;
    e.wdata    = $urandom;
    e.rword    = $urandom;
    e.waitN    = 4'($urandom % 5);
    return e;
  endfunction

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errCount++;
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      errCount++;
      $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
    end
  endtask

  task automatic checkTrue(input string what, input logic cond);
    assert (cond) else begin
      errCount++;
      $display("ERROR time=%0t %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  // dir 0 is Amiga to PCI
  // IDSEL from A20..A16 on config cycles only
  task automatic fillTable();
    tbl[0] = makeEntry(1'b0, 32'h0040_1000, 1'b0, 1'b0, 1'b0, 5'h00);
    tbl[1] = makeEntry(1'b0, 32'h0040_2004, 1'b1, 1'b0, 1'b1, 5'h00);
    tbl[2] = makeEntry(1'b1, 32'h0001_0008, 1'b1, 1'b0, 1'b0, 5'h00);
    tbl[3] = makeEntry(1'b1, 32'h0002_000C, 1'b0, 1'b0, 1'b1, 5'h00);
    tbl[4] = makeEntry(1'b0, 32'h0015_0004, 1'b1, 1'b1, 1'b1, 5'h15);
    tbl[5] = makeEntry(1'b0, 32'h000A_0010, 1'b0, 1'b1, 1'b0, 5'h0A);
    tbl[6] = makeEntry(1'b0, 32'h001F_0000, 1'b0, 1'b0, 1'b0, 5'h00);
    tbl[7] = makeEntry(1'b1, 32'h0008_0100, 1'b1, 1'b0, 1'b0, 5'h00);
  endtask

  // Master raises its request and holds the cycle until done
  task automatic postRequest(input int idx);
    cycleReqT c;
    c.addr  = tbl[idx].addr;
    c.wdata = tbl[idx].wdata;
    c.rnw   = tbl[idx].rnw;
    c.cfg   = tbl[idx].cfg;
    c.dma   = tbl[idx].isDma;
    if (tbl[idx].isDma) begin
      dmaCycle = c;
      dmaReq   = 1'b1;
    end else begin
      cpuCycle = c;
      cpuReq   = 1'b1;
    end
  endtask

  // Serve one posted cycle as PCI target and Amiga memory
  task automatic runCycle(input int idx, input bit checkLatency);
    entryT  e;
    masterT expMst;
    int     waited;
    int     dpCycles;
    e        = tbl[idx];
    expMst   = e.isDma ? mstDma : mstCpu;
    waited   = 0;
    dpCycles = 0;
    pciAdIn     = e.rword;
    amigaDataIn = e.wdata;
    pciTrdy     = 1'b0;
    while (!dut_i.phaseA && waited < waitLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    checkTrue("timeout waiting for phaseA", dut_i.phaseA);
    if (dut_i.phaseA) begin
      if (checkLatency) begin
        checkVal("request to phaseA cycles", 32'(waited), 32'd2);
      end
      checkVal("grant", 32'(grant), 32'(expMst));
      checkBit("pciAd.oe", pciAd.oe, 1'b1);
      checkVal("pciAd.data", pciAd.data, e.addr);
      checkBit("addrBufEn", addrBufEn, 1'b1);
      checkBit("amigaData.oe", amigaData.oe, 1'b0);
      waited = 0;
      while (!cycleDone && waited < waitLimit) begin
        @(posedge clk);
        #1;
        waited++;
        if (dut_i.dataPhase) begin
          dpCycles++;
          checkBit("pciDir", pciDir, e.expDir);
          checkBit("addrBufEn", addrBufEn, 1'b0);
          checkVal("idsel", 32'(idsel), 32'(e.expIdsel));
          if (e.expDir) begin
            checkBit("pciAd.oe", pciAd.oe, 1'b0);
            checkBit("amigaData.oe", amigaData.oe, 1'b1);
            checkVal("amigaData.data", amigaData.data, byteReverse(e.rword));
          end else begin
            checkBit("pciAd.oe", pciAd.oe, 1'b1);
            checkBit("amigaData.oe", amigaData.oe, 1'b0);
            checkVal("pciAd.data", pciAd.data, byteReverse(e.wdata));
          end
          // TRDY low for the first waitN data phase cycles
          pciTrdy = (dpCycles > int'(e.waitN));
        end
      end
      checkTrue("timeout waiting for cycleDone", cycleDone);
      checkVal("data phase cycles", 32'(dpCycles), 32'(int'(e.waitN) + 1));
      checkVal("grant at done", 32'(grant), 32'(expMst));
      checkVal("idsel after done", 32'(idsel), 32'd0);
      checkVal("cycleRdata", cycleRdata,
               e.expDir ? byteReverse(e.rword) : byteReverse(e.wdata));
    end
    lastMst = expMst;
    pciTrdy = 1'b0;
    if (e.isDma) begin
      dmaReq = 1'b0;
    end else begin
      cpuReq = 1'b0;
    end
    @(posedge clk);
    #1;
    // Single done pulse and bus released
    checkBit("cycleDone after pulse", cycleDone, 1'b0);
    checkVal("grant after done", 32'(grant), 32'(mstNone));
  endtask

  // Both masters at once
  // The one not served last goes first
  task automatic tieRound(input int cpuIdx, input int dmaIdx);
    postRequest(cpuIdx);
    postRequest(dmaIdx);
    if (lastMst == mstCpu) begin
      runCycle(dmaIdx, 1'b1);
      runCycle(cpuIdx, 1'b0);
    end else begin
      runCycle(cpuIdx, 1'b1);
      runCycle(dmaIdx, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(75));
    errCount    = 0;
    rst         = 1'b1;
    cpuReq      = 1'b0;
    dmaReq      = 1'b0;
    cpuCycle    = '0;
    dmaCycle    = '0;
    pciTrdy     = 1'b0;
    pciAdIn     = '0;
    amigaDataIn = '0;
    // First tie goes to the master picked by startWithDma
    lastMst = startWithDma ? mstCpu : mstDma;
    fillTable();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    checkVal("grant after reset", 32'(grant), 32'(mstNone));
    checkBit("phaseA after reset", dut_i.phaseA, 1'b0);
    checkBit("dataPhase after reset", dut_i.dataPhase, 1'b0);
    checkBit("cycleDone after reset", cycleDone, 1'b0);
    checkBit("pciAd.oe after reset", pciAd.oe, 1'b0);
    checkBit("amigaData.oe after reset", amigaData.oe, 1'b0);
    checkBit("addrBufEn after reset", addrBufEn, 1'b0);
    checkVal("idsel after reset", 32'(idsel), 32'd0);
    // Tie straight out of reset
    tieRound(0, 2);
    for (int i = 0; i < numEntries; i++) begin
      postRequest(i);
      runCycle(i, 1'b1);
    end
    tieRound(1, 3);
    // Lone CPU cycle so the next tie starts with DMA
    postRequest(5);
    runCycle(5, 1'b1);
    tieRound(0, 7);
    assertErrs = dut_i.asserts_i.failCount;
    $display("Errors: checks=%0d assertions=%0d", errCount, assertErrs);
    if (errCount == 0 && assertErrs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
hdl/apciBusPkg.sv
hdl/apciCtrlPkg.sv
hdl/pciBusArbiter.sv
hdl/pciCycleSeq.sv
hdl/adBuffers.sv
hdl/apciBridgeTop.sv
verification/apciBridge_asserts.sv
verification/apciBridgeTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := apciBridgeTb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+1000
FAIL_MSG   := Simulation finished: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
